//--- fetch_top.f
rtl/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/fetch_pc.sv
rtl/imem_rom.sv
rtl/issue_filter.sv
rtl/fetch_top.sv
tb/fetch_top_props.sv
tb/fetch_top_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := fetch_top_tb
FILELIST   := fetch_top.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# a crash or assertion stop without a verdict counts as a failure
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- program.hex
// one 32-bit instruction word per line, ROM index 0 first
A0000000
A0000001
A0000002
A0000003
A0000004
A0000005
A0000006
A0000007
A0000008
A0000009
A000000A
A000000B
A000000C
A000000D
A000000E
A000000F
A0000010
A0000011
A0000012
A0000013
A0000014
A0000015
A0000016
A0000017
A0000018
A0000019
A000001A
A000001B
A000001C
A000001D
A000001E
A000001F

//--- tb/fetch_top_tb.sv
// ========================================
// testbench for the fetch front end
// walks a table of redirect and stall scenarios, with
// redirects sometimes raised inside a random stall,
// and checks every issued word against a reference
// pc stream and program.hex
// run from the project root so program.hex is found
// ========================================
`timescale 1ns/1ps
`default_nettype none

module fetch_top_tb;

    localparam logic [31:0] SEED   = 32'h440e_7714;
    localparam logic [4:0]  M_JUMP = 5'b00001;           // request bits of a table row
    localparam logic [4:0]  M_EXC  = 5'b00010;
    localparam logic [4:0]  M_IRQ  = 5'b00100;
    localparam logic [4:0]  M_MRET = 5'b01000;
    localparam logic [4:0]  M_SYS  = 5'b10000;           // held for three cycles

    // one scenario of the table
    typedef struct packed {
        logic [7:0]  settle;                            // quiet cycles before the request
        logic [4:0]  req;                               // requests raised in the same cycle
        logic [31:0] target;                            // jump_target_i
        logic [31:0] mtvec;
        logic [31:0] mepc;
        logic [3:0]  stall;                             // longest random stall, 0 for none
        logic [31:0] exp_first;                         // first pc of the new path
        logic        exp_mis;                           // trap_misaligned_o expected to pulse
        logic [3:0]  cnt;                               // words of the new path to check
    } row_t;

    logic              clk = 1'b0;
    logic              reset_n;
    logic              sys_reset_i, jump_i, exception_i, interrupt_ack_i, mret_i, stall_i;
    logic [31:0]       jump_target_i, mtvec_i, mepc_i;
    fetch_pkg::issue_t issue_o;
    logic              trap_misaligned_o;

    row_t        rows[$];
    logic [31:0] img [0:fetch_pkg::IMEM_WORDS-1];       // reference copy of the ROM image
    logic [31:0] cur_tgt, cur_mtvec, cur_mepc;          // data inputs of the current row
    logic [31:0] exp_pc;                                // next pc on the live path
    logic [31:0] pend_tgt;                              // path the DUT must switch to
    logic [31:0] first_pc;
    logic        pend;                                  // a redirect has not reached issue yet
    logic        mis_seen;
    int          old_cnt, nwords, words, errors, row_err, cycles;
    int          limit = 0;

    fetch_top DUT (
        .clk               (clk),
        .reset_n           (reset_n),
        .sys_reset_i       (sys_reset_i),
        .jump_i            (jump_i),
        .jump_target_i     (jump_target_i),
        .exception_i       (exception_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .mret_i            (mret_i),
        .mtvec_i           (mtvec_i),
        .mepc_i            (mepc_i),
        .stall_i           (stall_i),
        .issue_o           (issue_o),
        .trap_misaligned_o (trap_misaligned_o)
    );

    bind fetch_top fetch_top_props u_props (
        .clk               (clk),
        .reset_n           (reset_n),
        .stall_i           (stall_i),
        .req_i             (req),
        .redir_tag_valid_i (redir_tag_valid),
        .issue_i           (issue_o),
        .trap_misaligned_i (trap_misaligned_o)
    );

    always #2 clk = ~clk;                               // 4 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: table not finished within %0d cycles", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic row_t make_row(input int settle, input logic [4:0] req,
                                      input logic [31:0] target, input logic [31:0] mtvec,
                                      input logic [31:0] mepc, input int stall,
                                      input logic [31:0] exp_first, input int mis,
                                      input int cnt);
        row_t r;
        r.settle    = 8'(settle);
        r.req       = req;
        r.target    = target;
        r.mtvec     = mtvec;
        r.mepc      = mepc;
        r.stall     = 4'(stall);
        r.exp_first = exp_first;
        r.exp_mis   = (mis != 0);
        r.cnt       = 4'(cnt);
        return r;
    endfunction

    // ========================================
    // reference model of the issued stream
    // ========================================
    task automatic check_issue();
        logic [31:0] pc;
        pc = issue_o.pc;
        if (issue_o.valid) begin
            words++;
            if (pend && pc == pend_tgt) begin
                pend     = 1'b0;                        // new path reached decode
                first_pc = pc;
                exp_pc   = pc + 32'd4;
                nwords   = 1;
            end else if (pc == exp_pc && (!pend || old_cnt == 0)) begin
                // one word read before the redirect edge may still drain
                if (pend) old_cnt++;
                exp_pc = exp_pc + 32'd4;
                nwords++;
            end else begin
                $display("Fail issue_o.pc: expected %h, got %h", pend ? pend_tgt : exp_pc, pc);
                errors++;
                row_err++;
                exp_pc = pc + 32'd4;                    // resync so one slip is reported once
            end
            if (issue_o.instr != img[pc[fetch_pkg::IMEM_AW+1:2]]) begin
                $display("Fail issue_o.instr at pc %h: expected %h, got %h",
                         pc, img[pc[fetch_pkg::IMEM_AW+1:2]], issue_o.instr);
                errors++;
                row_err++;
            end
        end
    endtask

    // drive on the falling edge, look at outputs once they settled
    task automatic run_cycle(input logic [4:0] rq, input logic stall);
        @(negedge clk);
        jump_i          = |(rq & M_JUMP);
        exception_i     = |(rq & M_EXC);
        interrupt_ack_i = |(rq & M_IRQ);
        mret_i          = |(rq & M_MRET);
        sys_reset_i     = |(rq & M_SYS);
        jump_target_i   = cur_tgt;
        mtvec_i         = cur_mtvec;
        mepc_i          = cur_mepc;
        stall_i         = stall;
        #1;
        check_issue();
        if (trap_misaligned_o) mis_seen = 1'b1;
    endtask

    task automatic apply_row(input row_t r, input int idx);
        int stall_len;
        cur_tgt   = r.target;
        cur_mtvec = r.mtvec;
        cur_mepc  = r.mepc;
        mis_seen  = 1'b0;
        row_err   = 0;
        for (int i = 0; i < int'(r.settle); i++) run_cycle(5'b0, 1'b0);
        if (r.stall != 4'd0) begin
            stall_len = 1 + int'($urandom % 32'(r.stall));
            for (int i = 0; i < stall_len; i++) begin
                run_cycle((i == stall_len / 2) ? r.req : 5'b0, 1'b1);   // raised mid stall
            end
        end else if (r.req != 5'b0) begin
            run_cycle(r.req, 1'b0);
        end
        if (r.req != 5'b0 || r.stall != 4'd0) begin
            pend     = 1'b1;
            pend_tgt = r.exp_first;
            old_cnt  = (r.req == 5'b0) ? 1 : 0;         // a plain stall lets no other word through
            nwords   = 0;
            if ((r.req & M_SYS) != 5'b0) repeat (2) run_cycle(M_SYS, 1'b0);
        end
        while (pend || nwords < int'(r.cnt)) run_cycle(5'b0, 1'b0);
        if (mis_seen != r.exp_mis) begin
            $display("Fail trap_misaligned_o: expected %h, got %h", r.exp_mis, mis_seen);
            errors++;
            row_err++;
        end
        $display("row %0d: first pc %h, %0d words in order, trap_misaligned %0b, %s",
                 idx, first_pc, nwords, mis_seen, (row_err == 0) ? "ok" : "mismatch");
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        reset_n = 1'b0;
        {sys_reset_i, jump_i, exception_i, interrupt_ack_i, mret_i, stall_i} = '0;
        jump_target_i = '0;
        mtvec_i       = '0;
        mepc_i        = '0;
        {cur_tgt, cur_mtvec, cur_mepc, first_pc} = '0;
        pend      = 1'b1;                               // reset acts as a redirect to the start
        pend_tgt  = fetch_pkg::START_ADDRESS;
        exp_pc    = '1;
        old_cnt   = 1;                                  // nothing from before reset may drain
        void'($urandom(SEED));
        $readmemh("program.hex", img);
        for (int i = 0; i < fetch_pkg::IMEM_WORDS; i++) begin
            if (img[i] !== 32'hA000_0000 + 32'(i)) begin
                $display("program.hex word %0d is %h, not the expected image", i, img[i]);
                errors++;
            end
        end
        //                     set req            target      mtvec       mepc     st first  m n
        rows.push_back(make_row(0, 5'b0,           32'h000, 32'h100, 32'h000, 0, 32'h000, 0, 6));
        rows.push_back(make_row(2, M_JUMP,         32'h040, 32'h100, 32'h000, 0, 32'h040, 0, 4));
        rows.push_back(make_row(1, M_EXC | M_JUMP, 32'h010, 32'h100, 32'h000, 0, 32'h100, 0, 3));
        rows.push_back(make_row(2, M_IRQ,          32'h000, 32'h184, 32'h000, 0, 32'h184, 0, 3));
        rows.push_back(make_row(1, M_MRET | M_EXC | M_JUMP,
                                                   32'h020, 32'h100, 32'h058, 0, 32'h058, 0, 4));
        rows.push_back(make_row(2, M_JUMP,         32'h046, 32'h120, 32'h000, 0, 32'h120, 1, 3));
        rows.push_back(make_row(2, M_MRET,         32'h000, 32'h0C0, 32'h031, 0, 32'h0C0, 1, 3));
        rows.push_back(make_row(1, M_JUMP,         32'h008, 32'h100, 32'h000, 6, 32'h008, 0, 5));
        rows.push_back(make_row(3, M_EXC,          32'h000, 32'h070, 32'h000, 9, 32'h070, 0, 4));
        rows.push_back(make_row(2, M_SYS | M_MRET | M_JUMP,
                                                   32'h044, 32'h100, 32'h048, 0, 32'h000, 0, 5));
        rows.push_back(make_row(1, M_JUMP,         32'h074, 32'h100, 32'h000, 4, 32'h074, 0, 6));
        rows.push_back(make_row(1, M_IRQ | M_JUMP, 32'h023, 32'h0A0, 32'h000, 0, 32'h0A0, 0, 3));
        // the live stream must resume after a stall without a skip or a repeat
        rows.push_back(make_row(1, 5'b0,           32'h000, 32'h100, 32'h000, 7, 32'h0B0, 0, 4));
        // reset, then per row its quiet, stall and word cycles plus pipeline slack
        limit = 4 + 20;
        foreach (rows[i]) begin
            limit += int'(rows[i].settle) + int'(rows[i].stall) + int'(rows[i].cnt) + 12;
        end
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        foreach (rows[i]) apply_row(rows[i], i);
        $display("rows %0d, words checked %0d, errors %0d", rows.size(), words, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/fetch_top_props.sv
// ========================================
// concurrent checks on the fetch front end
// bound into fetch_top from the testbench
// ========================================
`timescale 1ns/1ps
`default_nettype none

module fetch_top_props (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  stall_i,
    input fetch_pkg::fetch_req_t req_i,               // current pc, tag and enable
    input logic                  redir_tag_valid_i,   // req_i.tag renewed at the last edge
    input fetch_pkg::issue_t     issue_i,
    input logic                  trap_misaligned_i
);

    logic [fetch_pkg::TAG_W-1:0] exp_tag;             // tag of the live path as decode sees it
    logic                        seen_fetch;          // at least one enabled fetch since reset

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exp_tag    <= '0;
            seen_fetch <= 1'b0;
        end else begin
            if (redir_tag_valid_i) exp_tag <= req_i.tag;
            if (req_i.en) seen_fetch <= 1'b1;
        end
    end

    a_stall_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |-> !issue_i.valid) else $error("issue_o.valid high during stall");

    a_trap_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        trap_misaligned_i |=> !trap_misaligned_i) else $error("trap_misaligned_o longer than one cycle");

    a_live_tag: assert property (@(posedge clk) disable iff (!reset_n)
        issue_i.valid |-> issue_i.tag == exp_tag) else $error("issued word carries a stale tag");

    a_boot_empty: assert property (@(posedge clk) disable iff (!reset_n)
        !seen_fetch |-> !issue_i.valid) else $error("valid word before the first fetch");

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
// ======================================
// fetch front end top level
// controller, fetch unit, instruction ROM and
// issue filter wired into one block
// an unstalled fetch reaches issue_o two enabled
// edges after its address is presented
// ======================================
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              sys_reset_i,
    input  logic              jump_i,
    input  logic [31:0]       jump_target_i,
    input  logic              exception_i,
    input  logic              interrupt_ack_i,
    input  logic              mret_i,
    input  logic [31:0]       mtvec_i,
    input  logic [31:0]       mepc_i,
    input  logic              stall_i,
    output fetch_pkg::issue_t issue_o,
    output logic              trap_misaligned_o
);

    fetch_pkg::redirect_t        redir;               // winning redirect this cycle
    logic                        fetch_en;            // whole front end advances
    fetch_pkg::fetch_req_t       req;                 // current pc and tag
    logic [31:0]                 pc_q;                // pc of the word in the ROM register
    logic [fetch_pkg::TAG_W-1:0] tag_q;               // tag of that word
    logic                        redir_tag_valid;     // req.tag just changed
    logic [31:0]                 rdata;               // ROM word

    fetch_ctrl u_ctrl (
        .clk               (clk),
        .reset_n           (reset_n),
        .sys_reset_i       (sys_reset_i),
        .jump_i            (jump_i),
        .jump_target_i     (jump_target_i),
        .exception_i       (exception_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .mret_i            (mret_i),
        .mtvec_i           (mtvec_i),
        .mepc_i            (mepc_i),
        .stall_i           (stall_i),
        .redir_o           (redir),
        .fetch_en_o        (fetch_en),
        .trap_misaligned_o (trap_misaligned_o)
    );

    fetch_pc u_pc (
        .clk               (clk),
        .reset_n           (reset_n),
        .redir_i           (redir),
        .fetch_en_i        (fetch_en),
        .req_o             (req),
        .pc_q_o            (pc_q),
        .tag_q_o           (tag_q),
        .redir_tag_valid_o (redir_tag_valid)
    );

    imem_rom u_rom (
        .clk     (clk),
        .req_i   (req),
        .rdata_o (rdata)
    );

    // the new path tag is the tag of the current request
    issue_filter u_filter (
        .clk             (clk),
        .reset_n         (reset_n),
        .fetch_en_i      (fetch_en),
        .pc_q_i          (pc_q),
        .tag_q_i         (tag_q),
        .rdata_i         (rdata),
        .new_tag_i       (req.tag),
        .new_tag_valid_i (redir_tag_valid),
        .issue_o         (issue_o)
    );

endmodule

`default_nettype wire

//--- rtl/issue_filter.sv
// ======================================
// issue filter
// registers the ROM word with its pc and tag and
// marks it valid only when the tag matches the
// current path, so wrong-path words never reach decode
// valid is dropped while the front end is stalled
// ======================================
`timescale 1ns/1ps
`default_nettype none

module issue_filter (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        fetch_en_i,       // stage advances at this edge
    input  logic [31:0]                 pc_q_i,           // pc of the word in rdata_i
    input  logic [fetch_pkg::TAG_W-1:0] tag_q_i,          // tag of the word in rdata_i
    input  logic [31:0]                 rdata_i,          // registered ROM word
    input  logic [fetch_pkg::TAG_W-1:0] new_tag_i,        // tag of the path now being fetched
    input  logic                        new_tag_valid_i,  // new_tag_i changed at the last edge
    output fetch_pkg::issue_t           issue_o
);

    logic [fetch_pkg::TAG_W-1:0] exp_q;                   // tag of the live path
    logic [fetch_pkg::TAG_W-1:0] exp_now;                 // includes a tag change arriving now
    logic                        valid_q;
    logic [31:0]                 pc_r;
    logic [31:0]                 instr_r;
    logic [fetch_pkg::TAG_W-1:0] tag_r;

    // the word in flight is judged against the newest tag, not the stored one
    assign exp_now = new_tag_valid_i ? new_tag_i : exp_q;

    // ======================================
    // control state
    // ======================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exp_q   <= '0;                                // matches the reset tag of fetch_pc
            valid_q <= 1'b0;
        end else begin
            if (new_tag_valid_i) begin
                exp_q <= new_tag_i;
            end
            if (fetch_en_i) begin
                valid_q <= (tag_q_i == exp_now);
            end else if (new_tag_valid_i) begin
                valid_q <= 1'b0;                          // a held word of the old path is dropped
            end
        end
    end

    // payload follows the fetch stage
    always_ff @(posedge clk) begin
        if (fetch_en_i) begin
            pc_r    <= pc_q_i;
            instr_r <= rdata_i;
            tag_r   <= tag_q_i;
        end
    end

    // ======================================
    // output to decode
    // ======================================
    always_comb begin
        issue_o.valid = valid_q && fetch_en_i;            // a held word is only taken once
        issue_o.pc    = pc_r;
        issue_o.instr = instr_r;
        issue_o.tag   = tag_r;
    end

endmodule

`default_nettype wire

//--- rtl/imem_rom.sv
// ======================================
// instruction ROM
// synchronous, word addressed, IMEM_WORDS deep
// image comes from program.hex at start of simulation
// output register loads only on an enabled fetch
// and keeps its word while the fetch stage holds
// ======================================
`timescale 1ns/1ps
`default_nettype none

module imem_rom (
    input  logic                  clk,
    input  fetch_pkg::fetch_req_t req_i,              // address and enable from fetch_pc
    output logic [31:0]           rdata_o             // word at req_i.addr one edge later
);

    logic [31:0] mem [0:fetch_pkg::IMEM_WORDS-1];     // ROM contents
    logic [fetch_pkg::IMEM_AW-1:0] index;             // word index, wraps every 128 bytes

    initial begin
        $readmemh("program.hex", mem);
    end

    // byte offset bits are dropped, upper bits alias
    assign index = req_i.addr[fetch_pkg::IMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (req_i.en) begin
            rdata_o <= mem[index];
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_pc.sv
// ======================================
// fetch unit
// holds the program counter and the path tag
// pc loads a redirect target at any edge and
// otherwise steps by 4 on enabled edges
// a fresh tag after each redirect lets the issue
// filter recognize words of an abandoned path
// ======================================
`timescale 1ns/1ps
`default_nettype none

module fetch_pc (
    input  logic                          clk,
    input  logic                          reset_n,
    input  fetch_pkg::redirect_t          redir_i,            // command from fetch_ctrl
    input  logic                          fetch_en_i,         // fetch stage advances
    output fetch_pkg::fetch_req_t         req_o,              // current pc and tag to ROM and filter
    output logic [31:0]                   pc_q_o,             // pc of the word now in the ROM output
    output logic [fetch_pkg::TAG_W-1:0]   tag_q_o,            // tag of that same word
    output logic                          redir_tag_valid_o   // req_o.tag was renewed at the last edge
);

    logic [31:0]                 pc;                  // address being fetched now
    logic [31:0]                 pc_q;                // follows the word through the ROM register
    logic [fetch_pkg::TAG_W-1:0] tag_cur;             // tag of the path that pc is on
    logic [fetch_pkg::TAG_W-1:0] tag_q;               // tag of the word in the ROM register
    logic                        redir_tag_valid_q;
    logic                        redirect;            // a real redirect is requested

    // a command without a cause is ignored
    assign redirect = redir_i.valid && (redir_i.kind != fetch_pkg::RD_NONE);

    // ======================================
    // pc control
    // ======================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= fetch_pkg::START_ADDRESS;
        end else if (redirect) begin
            pc <= redir_i.target;                     // loads even while stalled
        end else if (fetch_en_i) begin
            pc <= pc + fetch_pkg::PC_STEP;
        end
    end

    // pc of the word that the ROM reads at this edge
    always_ff @(posedge clk) begin
        if (fetch_en_i) begin
            pc_q <= pc;
        end
    end

    // ======================================
    // tag calculator
    // ======================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_cur           <= '0;
            tag_q             <= '1;                  // the empty stage after reset never matches
            redir_tag_valid_q <= 1'b0;
        end else begin
            redir_tag_valid_q <= redirect;            // new tag is visible on req_o.tag now
            if (redirect) begin
                tag_cur <= tag_cur + 1'b1;
            end
            if (fetch_en_i) begin
                tag_q <= tag_cur;                     // old tag still rides with the last old word
            end
        end
    end

    // ======================================
    // outputs
    // ======================================
    assign req_o.addr        = pc;
    assign req_o.tag         = tag_cur;
    assign req_o.en          = fetch_en_i;
    assign pc_q_o            = pc_q;
    assign tag_q_o           = tag_q;
    assign redir_tag_valid_o = redir_tag_valid_q;

endmodule

`default_nettype wire

//--- rtl/fetch_ctrl.sv
// ======================================
// front-end controller
// ranks the pc redirect requests, turns misaligned
// targets into a trap to mtvec and runs the small
// boot / run / hold FSM that produces fetch_en
// purely combinational to redir_o and fetch_en_o
// ======================================
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  sys_reset_i,          // level, parks fetch at START_ADDRESS
    input  logic                  jump_i,               // strobe from execute
    input  logic [31:0]           jump_target_i,
    input  logic                  exception_i,          // strobe, goes to mtvec
    input  logic                  interrupt_ack_i,      // strobe, goes to mtvec
    input  logic                  mret_i,               // strobe, goes to mepc
    input  logic [31:0]           mtvec_i,
    input  logic [31:0]           mepc_i,
    input  logic                  stall_i,              // level, holds the whole front end
    output fetch_pkg::redirect_t  redir_o,
    output logic                  fetch_en_o,
    output logic                  trap_misaligned_o     // one cycle after the offending request
);

    fetch_pkg::ctrl_state_e    state_q, state_d;
    fetch_pkg::redirect_kind_e sel_kind;                // winner of the priority ranking
    logic [31:0]               sel_target;              // target of the winner before the check
    logic                      misaligned;              // winner points off a word boundary

    // ======================================
    // state machine
    // ======================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::FS_BOOT: state_d = sys_reset_i ? fetch_pkg::FS_HOLD : fetch_pkg::FS_RUN;
            fetch_pkg::FS_RUN:  if (sys_reset_i) state_d = fetch_pkg::FS_HOLD;
            fetch_pkg::FS_HOLD: if (!sys_reset_i) state_d = fetch_pkg::FS_RUN;
            default:            state_d = fetch_pkg::FS_BOOT;     // unused encoding recovers
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q           <= fetch_pkg::FS_BOOT;
            trap_misaligned_o <= 1'b0;
        end else begin
            state_q           <= state_d;
            trap_misaligned_o <= misaligned;                      // registered flag, one cycle wide
        end
    end

    // ======================================
    // redirect ranking
    // ======================================
    always_comb begin
        sel_kind   = fetch_pkg::RD_NONE;
        sel_target = fetch_pkg::START_ADDRESS;
        if (sys_reset_i) begin
            // only the entry cycle loads the pc, so the tag does not spin while held
            if (state_q != fetch_pkg::FS_HOLD) begin
                sel_kind   = fetch_pkg::RD_SYSRST;
                sel_target = fetch_pkg::START_ADDRESS;
            end
        end else if (mret_i) begin
            sel_kind   = fetch_pkg::RD_MRET;
            sel_target = mepc_i;
        end else if (exception_i || interrupt_ack_i) begin
            sel_kind   = fetch_pkg::RD_TRAP;
            sel_target = mtvec_i;
        end else if (jump_i) begin
            sel_kind   = fetch_pkg::RD_JUMP;
            sel_target = jump_target_i;
        end
    end

    // without compressed words any target off a 4-byte boundary traps
    assign misaligned = (sel_kind != fetch_pkg::RD_NONE) && (sel_target[1:0] != 2'b00);

    assign redir_o.valid  = (sel_kind != fetch_pkg::RD_NONE);
    assign redir_o.kind   = misaligned ? fetch_pkg::RD_TRAP : sel_kind;
    assign redir_o.target = misaligned ? mtvec_i : sel_target;

    // boot slot stays empty, sys_reset and stall freeze the fetch stage
    assign fetch_en_o = (state_q != fetch_pkg::FS_BOOT) && !sys_reset_i && !stall_i;

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
// ======================================
// shared definitions of the fetch front end
// holds the reset pc, ROM geometry, tag width,
// redirect and state encodings and the packed
// structs passed between controller, fetch unit,
// ROM and issue filter
// every user reaches these by fetch_pkg::name
// ======================================
`default_nettype none

package fetch_pkg;

    // ======================================
    // constants
    // ======================================
    localparam logic [31:0] START_ADDRESS = 32'h0000_0000;  // pc after reset and after sys_reset
    localparam int          IMEM_WORDS    = 32;             // instruction ROM depth in words
    localparam int          IMEM_AW       = 5;              // ROM index width, log2 of the depth
    localparam int          TAG_W         = 3;              // width of the path tag
    localparam logic [31:0] PC_STEP       = 32'd4;          // no compressed words, so pc steps by 4

    // ======================================
    // encodings
    // ======================================

    // cause of a pc redirect, in no particular priority order
    typedef enum logic [2:0] {
        RD_NONE,                                            // no redirect this cycle
        RD_JUMP,                                            // taken jump or branch
        RD_TRAP,                                            // exception, interrupt or misaligned target
        RD_MRET,                                            // return from machine trap to mepc
        RD_SYSRST                                           // synchronous system reset
    } redirect_kind_e;

    typedef enum logic [1:0] {
        FS_BOOT,                                            // first cycle after reset, nothing fetched
        FS_RUN,                                             // normal fetching, stall_i gates it
        FS_HOLD                                             // sys_reset held, fetch parked at start
    } ctrl_state_e;

    // ======================================
    // packed structs
    // ======================================

    // one redirect command from fetch_ctrl to fetch_pc
    typedef struct packed {
        logic           valid;                              // load target into pc at the next edge
        redirect_kind_e kind;                               // why the pc moves
        logic [31:0]    target;                             // new pc, always word aligned
    } redirect_t;

    // fetch request seen by the ROM and the filter
    typedef struct packed {
        logic [31:0]      addr;                             // byte address, equal to the current pc
        logic [TAG_W-1:0] tag;                              // path tag of this fetch
        logic             en;                               // the fetch stage advances at this edge
    } fetch_req_t;

    // word handed to decode
    typedef struct packed {
        logic             valid;                            // word belongs to the current path
        logic [31:0]      pc;                               // address the word came from
        logic [31:0]      instr;                            // raw instruction word
        logic [TAG_W-1:0] tag;                              // path tag it was fetched under
    } issue_t;

endpackage

`default_nettype wire
